//--- project.f
+incdir+src
+incdir+verif
src/predecode_pkg.sv
src/branch_classifier.sv
src/return_stack.sv
src/branch_predictor.sv
src/predecode_stage.sv
verif/predecode_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module predecode_tb -f project.f -o predecode_sim

# A failing run also exits non-zero. The search below decides.
result=$(./obj_dir/predecode_sim 2>&1) || true
echo "$result"

if echo "$result" | grep -q "All tests passed"
then
        exit 0
fi
exit 1

//--- verif/predecode_tb_table.svh
`ifndef PREDECODE_TB_TABLE_SVH
`define PREDECODE_TB_TABLE_SVH

// Columns: mode, instr, pc, taken, BTB valid, BTB target, expected taken,
// expected predicted PC, {decode valid, redirect valid, BTB clear}, redirect target.
typedef struct packed {
        logic [1:0]            mode;
        logic [`PD_XLEN-1:0]   instr;
        logic [`PD_XLEN-1:0]   pc;
        predecode_pkg::taken_e taken;
        logic                  btb_valid;
        logic [`PD_XLEN-1:0]   btb_target;
        predecode_pkg::taken_e exp_taken;
        logic [`PD_XLEN-1:0]   exp_ppc;
        logic [2:0]            exp_flags;
        logic [`PD_XLEN-1:0]   exp_rd_target;
} row_t;

// Row modes.
localparam logic [1:0] M_RUN = 2'd0;
localparam logic [1:0] M_STL = 2'd1;
localparam logic [1:0] M_CLR = 2'd2;
localparam logic [1:0] M_RND = 2'd3;

localparam predecode_pkg::taken_e T_SNT = predecode_pkg::strongly_not_taken;
localparam predecode_pkg::taken_e T_WNT = predecode_pkg::weakly_not_taken;
localparam predecode_pkg::taken_e T_WT  = predecode_pkg::weakly_taken;
localparam predecode_pkg::taken_e T_ST  = predecode_pkg::strongly_taken;

localparam int NUM_ROWS = 23;

// Random rows keep the distance from the true target in the BTB target column.
localparam row_t ROWS [NUM_ROWS] = '{
        // Plain and conditional B.
        '{M_RUN, 32'hEA000010, 32'h1000, T_SNT, 1'b0, 32'h0, T_ST, 32'h1048, 3'b110, 32'h1048},
        '{M_RUN, 32'hEA000010, 32'h2000, T_SNT, 1'b1, 32'h2048, T_ST, 32'h2048, 3'b100, 32'h0},
        '{M_RUN, 32'h1A000010, 32'h3000, T_WNT, 1'b0, 32'h0, T_WNT, 32'h3004, 3'b100, 32'h0},
        '{M_RUN, 32'h1A000010, 32'h3100, T_WT, 1'b0, 32'h0, T_WT, 32'h3148, 3'b110, 32'h3148},
        '{M_RUN, 32'hEAFFFFFE, 32'h4000, T_WNT, 1'b0, 32'h0, T_ST, 32'h4000, 3'b110, 32'h4000},
        // Calls and returns, then two nested levels.
        '{M_RUN, 32'hEB000100, 32'h5000, T_SNT, 1'b0, 32'h0, T_ST, 32'h5408, 3'b110, 32'h5408},
        '{M_RUN, 32'hE12FFF1E, 32'h5408, T_SNT, 1'b0, 32'h0, T_ST, 32'h5004, 3'b110, 32'h5004},
        '{M_RUN, 32'hEB000200, 32'h6000, T_SNT, 1'b1, 32'h6808, T_ST, 32'h6808, 3'b100, 32'h0},
        '{M_RUN, 32'hE1A0F00E, 32'h6808, T_SNT, 1'b1, 32'h6004, T_ST, 32'h6004, 3'b100, 32'h0},
        '{M_RUN, 32'hEB000010, 32'h7000, T_SNT, 1'b0, 32'h0, T_ST, 32'h7048, 3'b110, 32'h7048},
        '{M_RUN, 32'hEB000010, 32'h7048, T_SNT, 1'b0, 32'h0, T_ST, 32'h7090, 3'b110, 32'h7090},
        '{M_RUN, 32'hE12FFF1E, 32'h7090, T_SNT, 1'b0, 32'h0, T_ST, 32'h704C, 3'b110, 32'h704C},
        '{M_RUN, 32'hE12FFF1E, 32'h704C, T_SNT, 1'b0, 32'h0, T_ST, 32'h7004, 3'b110, 32'h7004},
        // BTB hit on a non-branch, then jump tables.
        '{M_RUN, 32'hE2811001, 32'h8000, T_WT, 1'b1, 32'h8100, T_SNT, 32'h8004, 3'b111, 32'h8004},
        '{M_RUN, 32'hE1A0F002, 32'h8100, T_WT, 1'b1, 32'h9000, T_WT, 32'h9000, 3'b100, 32'h0},
        '{M_RUN, 32'hE1A0F002, 32'h8200, T_SNT, 1'b0, 32'h0, T_SNT, 32'h8204, 3'b100, 32'h0},
        // Stall and clear around a pending return.
        '{M_RUN, 32'hEB000010, 32'hA000, T_SNT, 1'b0, 32'h0, T_ST, 32'hA048, 3'b110, 32'hA048},
        '{M_STL, 32'hE2811001, 32'hA048, T_WT, 1'b0, 32'h0, T_SNT, 32'hA04C, 3'b100, 32'h0},
        '{M_CLR, 32'hEB000010, 32'hB000, T_SNT, 1'b0, 32'h0, T_SNT, 32'h0, 3'b000, 32'h0},
        '{M_RUN, 32'hE12FFF1E, 32'hA04C, T_SNT, 1'b0, 32'h0, T_ST, 32'hA004, 3'b110, 32'hA004},
        // Random unconditional B with a BTB hit, no BTB entry and a BTB miss.
        '{M_RND, 32'hEA000000, 32'h0, T_SNT, 1'b1, 32'h0, T_ST, 32'h0, 3'b100, 32'h0},
        '{M_RND, 32'hEA000000, 32'h0, T_SNT, 1'b0, 32'h0, T_ST, 32'h0, 3'b110, 32'h0},
        '{M_RND, 32'hEA000000, 32'h0, T_WNT, 1'b1, 32'h4, T_ST, 32'h0, 3'b110, 32'h0}
};

`endif

//--- verif/predecode_tb.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_tb;

localparam int CLK_PERIOD = 4;
localparam int SEED       = 73828;

logic                          i_clk;
logic                          i_reset;
logic                          i_stall;
logic                          i_clear;
predecode_pkg::fetch_bundle_t  i_fetch;
predecode_pkg::decode_bundle_t o_decode;
predecode_pkg::redirect_t      o_redirect;

`include "predecode_tb_table.svh"

// A row takes at most six cycles.
localparam int WATCHDOG_CYCLES = NUM_ROWS * 10 + 100;

// MOV r0, r0 as the wrong-path word behind each row.
localparam logic [`PD_XLEN-1:0] IDLE_INSTR = 32'hE1A00000;

predecode_stage dut_i
(
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_fetch    (i_fetch),
        .i_stall    (i_stall),
        .i_clear    (i_clear),
        .o_decode   (o_decode),
        .o_redirect (o_redirect)
);

// --------------------------------------------------
// Helpers.
// --------------------------------------------------

function automatic string test_name(input int idx, input string what);
        return $sformatf("row %0d %s", idx, what);
endfunction

task automatic check_equal(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        if ( actual !== expected )
        begin
                $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
                $display("Some tests failed");
                $fatal(1, "value mismatch");
        end
endtask

// Unconditional B at a random PC. The target follows the static rule.
function automatic row_t make_random_row(input row_t r);
        logic [`PD_XLEN-1:0] target;

        r.pc          = $urandom & 32'hFFFF_FFFC;
        r.instr[23:0] = 24'($urandom);
        target        = r.pc + 32'd8 + {{6{r.instr[23]}}, r.instr[23:0], 2'b00};
        if ( r.btb_valid )
        begin
                r.btb_target = target + r.btb_target;
        end
        r.exp_taken     = T_ST;
        r.exp_ppc       = target;
        r.exp_rd_target = target;
        return r;
endfunction

task automatic drive_fetch(input logic [`PD_XLEN-1:0] instr, input logic [`PD_XLEN-1:0] pc,
                           input predecode_pkg::taken_e taken, input logic btb_valid,
                           input logic [`PD_XLEN-1:0] btb_target);
        i_fetch.instr      = instr;
        i_fetch.valid      = 1'b1;
        i_fetch.pc         = pc;
        i_fetch.taken      = taken;
        i_fetch.btb_valid  = btb_valid;
        i_fetch.btb_target = btb_target;
endtask

task automatic check_result(input int idx, input row_t r);
        check_equal(test_name(idx, "decode valid"), 128'(r.exp_flags[2]),
                    128'(o_decode.valid));
        check_equal(test_name(idx, "redirect valid"), 128'(r.exp_flags[1]),
                    128'(o_redirect.valid));
        check_equal(test_name(idx, "btb clear"), 128'(r.exp_flags[0]),
                    128'(o_redirect.clear_btb));
        if ( r.exp_flags[2] )
        begin
                check_equal(test_name(idx, "instr"), 128'(r.instr), 128'(o_decode.instr));
                check_equal(test_name(idx, "pc"), 128'(r.pc), 128'(o_decode.pc));
                check_equal(test_name(idx, "taken"), 128'(r.exp_taken), 128'(o_decode.taken));
                check_equal(test_name(idx, "ppc"), 128'(r.exp_ppc), 128'(o_decode.ppc));
        end
        if ( r.exp_flags[1] )
        begin
                check_equal(test_name(idx, "redirect target"), 128'(r.exp_rd_target),
                            128'(o_redirect.target));
        end
endtask

task automatic run_row(input int idx);
        row_t                          r;
        predecode_pkg::decode_bundle_t held;
        logic [`PD_XLEN-1:0]           idle_pc;

        r = ROWS[idx];
        if ( r.mode == M_RND )
        begin
                r = make_random_row(r);
        end

        drive_fetch(r.instr, r.pc, r.taken, r.btb_valid, r.btb_target);
        i_stall = (r.mode == M_STL);
        i_clear = (r.mode == M_CLR);

        // Three stalled edges, then the word goes in.
        if ( r.mode == M_STL )
        begin
                held = o_decode;
                repeat (3)
                begin
                        @(posedge i_clk);
                        #1;
                        check_equal(test_name(idx, "stall hold"), 128'(held), 128'(o_decode));
                end
                i_stall = 1'b0;
        end

        @(posedge i_clk);
        #1;
        i_clear = 1'b0;
        check_result(idx, r);

        // A redirect must flush the word right behind it.
        idle_pc = r.pc + `PD_INSTR_STEP;
        drive_fetch(IDLE_INSTR, idle_pc, T_SNT, 1'b0, '0);
        @(posedge i_clk);
        #1;
        check_equal(test_name(idx, "wrong path valid"), 128'(!r.exp_flags[1]),
                    128'(o_decode.valid));
endtask

// --------------------------------------------------
// Clock, watchdog and main sequence.
// --------------------------------------------------

initial
begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

initial
begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out before the table was done");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
end

initial
begin
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_clear = 1'b0;
        i_fetch = '0;
        void'($urandom(SEED));

        repeat (5) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_equal("reset decode valid", '0, 128'(o_decode.valid));
        check_equal("reset redirect valid", '0, 128'(o_redirect.valid));
        check_equal("reset btb clear", '0, 128'(o_redirect.clear_btb));

        for (int idx = 0; idx < NUM_ROWS; idx++)
        begin
                run_row(idx);
        end

        $display("All tests passed");
        $finish;
end

endmodule : predecode_tb

//--- src/predecode_stage.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module predecode_stage
(
        input  logic                          i_clk,
        input  logic                          i_reset,

        // From fetch.
        input  predecode_pkg::fetch_bundle_t  i_fetch,

        // Pipeline control. Clear wins over stall.
        input  logic                          i_stall,
        input  logic                          i_clear,

        // To the next stage.
        output predecode_pkg::decode_bundle_t o_decode,

        // To fetch and the BTB.
        output predecode_pkg::redirect_t      o_redirect
);

predecode_pkg::branch_class_e  cls;
predecode_pkg::taken_e         taken_nxt;
predecode_pkg::redirect_t      redirect_nxt;
predecode_pkg::decode_bundle_t decode_nxt;
logic [`PD_XLEN-1:0]           offset;
logic [`PD_XLEN-1:0]           ras_top;
logic [`PD_XLEN-1:0]           push_addr;
logic [`PD_XLEN-1:0]           ppc_nxt;
logic                          push;
logic                          pop;
logic                          flush;
logic                          commit;

// --------------------------------------------------
// Flush and commit.
// --------------------------------------------------

// Own redirect kills the wrong-path word sitting at the input.
assign flush  = i_clear || (o_redirect.valid && !i_stall);

// Stack moves together with the output register.
assign commit = !i_stall && !flush;

// --------------------------------------------------
// Units.
// --------------------------------------------------

branch_classifier u_classifier
(
        .i_instr  (i_fetch.instr),
        .i_valid  (i_fetch.valid),
        .o_class  (cls),
        .o_offset (offset)
);

branch_predictor u_predictor
(
        .i_fetch     (i_fetch),
        .i_class     (cls),
        .i_offset    (offset),
        .i_ras_top   (ras_top),
        .o_taken     (taken_nxt),
        .o_ppc       (ppc_nxt),
        .o_redirect  (redirect_nxt),
        .o_push      (push),
        .o_pop       (pop),
        .o_push_addr (push_addr)
);

return_stack #(
        .DEPTH (`PD_RAS_DEPTH)
)
u_ras
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_commit    (commit),
        .i_push      (push),
        .i_pop       (pop),
        .i_push_addr (push_addr),
        .o_top       (ras_top)
);

always_comb
begin
        decode_nxt.instr = i_fetch.instr;
        decode_nxt.valid = i_fetch.valid;
        decode_nxt.pc    = i_fetch.pc;
        decode_nxt.taken = taken_nxt;
        decode_nxt.ppc   = ppc_nxt;
end

// --------------------------------------------------
// Output register.
// --------------------------------------------------

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                o_decode.valid <= 1'b0;
                o_redirect     <= '0;
        end
        else if ( flush )
        begin
                o_decode.valid       <= 1'b0;
                o_redirect.valid     <= 1'b0;
                o_redirect.clear_btb <= 1'b0;
        end
        else if ( !i_stall )
        begin
                o_decode   <= decode_nxt;
                o_redirect <= redirect_nxt;
        end
end

// A redirect lives for exactly one accepted cycle.
a_redirect_dropped : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_redirect.valid && !i_stall |=> !o_redirect.valid
);

// Stall freezes the decode bundle unless a clear overrides it.
a_stall_holds : assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_stall && !i_clear |=> $stable(o_decode)
);

endmodule : predecode_stage

//--- src/branch_predictor.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module branch_predictor
(
        // Word and guess from fetch.
        input  predecode_pkg::fetch_bundle_t i_fetch,

        // From the classifier.
        input  predecode_pkg::branch_class_e i_class,
        input  logic [`PD_XLEN-1:0]          i_offset,

        // Top of the return stack.
        input  logic [`PD_XLEN-1:0]          i_ras_top,

        // Updated guess.
        output predecode_pkg::taken_e        o_taken,
        output logic [`PD_XLEN-1:0]          o_ppc,
        output predecode_pkg::redirect_t     o_redirect,

        // Return stack requests.
        output logic                         o_push,
        output logic                         o_pop,
        output logic [`PD_XLEN-1:0]          o_push_addr
);

localparam logic [`PD_XLEN-1:0] STEP = `PD_INSTR_STEP;

logic                cond_al;
logic                guess_taken;
logic                mismatch;
logic [`PD_XLEN-1:0] pc_next;
logic [`PD_XLEN-1:0] pc_plus_8;
logic [`PD_XLEN-1:0] target;

// --------------------------------------------------
// Static rule inputs.
// --------------------------------------------------

assign cond_al = (i_fetch.instr[31:28] == `PD_COND_AL);

assign guess_taken = cond_al ||
                     (i_fetch.taken == predecode_pkg::weakly_taken) ||
                     (i_fetch.taken == predecode_pkg::strongly_taken);

// Architectural PC reads two instructions ahead.
assign pc_next   = i_fetch.pc + STEP;
assign pc_plus_8 = pc_next + STEP;

// Returns go to the stack, everything else is PC-relative.
assign target = (i_class == predecode_pkg::class_return) ? i_ras_top :
                                                           pc_plus_8 + i_offset;

assign mismatch = !i_fetch.btb_valid || (i_fetch.btb_target != target);

assign o_push_addr = pc_next;

// --------------------------------------------------
// Prediction by class.
// --------------------------------------------------

always_comb
begin
        o_taken    = i_fetch.taken;
        o_ppc      = pc_next;
        o_redirect = '0;
        o_push     = 1'b0;
        o_pop      = 1'b0;

        case ( i_class )
        predecode_pkg::class_branch,
        predecode_pkg::class_call,
        predecode_pkg::class_return:
        begin
                // Not taken falls through to PC+4.
                if ( guess_taken )
                begin
                        o_ppc             = target;
                        o_redirect.valid  = mismatch;
                        o_redirect.target = target;
                        o_push = (i_class == predecode_pkg::class_call);
                        o_pop  = (i_class == predecode_pkg::class_return);

                        if ( cond_al )
                        begin
                                o_taken = predecode_pkg::strongly_taken;
                        end
                end
        end

        predecode_pkg::class_jump_table:
        begin
                // Trust the BTB, the ALU will correct it.
                o_ppc = i_fetch.btb_valid ? i_fetch.btb_target : pc_next;
        end

        predecode_pkg::class_other:
        begin
                o_taken = predecode_pkg::strongly_not_taken;

                // BTB hit on a non-branch. Undo the jump and drop the entry.
                if ( i_fetch.btb_valid )
                begin
                        o_redirect.valid     = 1'b1;
                        o_redirect.target    = pc_next;
                        o_redirect.clear_btb = 1'b1;
                end
        end

        default:
        begin
                o_taken = predecode_pkg::strongly_not_taken;
        end
        endcase
end

// A bubble must never steer fetch.
always_comb
begin
        assert ( !o_redirect.valid || i_fetch.valid )
        else $error("redirect raised on an invalid fetch word");
end

endmodule : branch_predictor

//--- src/return_stack.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module return_stack #(
        parameter int DEPTH = 8
)
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Stack only moves when the stage advances.
        input  logic                i_commit,
        input  logic                i_push,
        input  logic                i_pop,
        input  logic [`PD_XLEN-1:0] i_push_addr,

        // Most recent return address.
        output logic [`PD_XLEN-1:0] o_top
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic [`PD_XLEN-1:0] entries [DEPTH];
logic [PTR_W-1:0]    ptr;
logic [PTR_W-1:0]    ptr_inc;
logic [PTR_W-1:0]    ptr_dec;

// Explicit wrap so that any depth works, not only powers of two.
assign ptr_inc = (ptr == PTR_W'(DEPTH-1)) ? '0 : ptr + 1'b1;
assign ptr_dec = (ptr == '0) ? PTR_W'(DEPTH-1) : ptr - 1'b1;

assign o_top = entries[ptr_dec];

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                ptr <= '0;
        end
        else if ( i_commit )
        begin
                if ( i_push )
                begin
                        ptr <= ptr_inc;
                end
                else if ( i_pop )
                begin
                        ptr <= ptr_dec;
                end
        end
end

always_ff @ ( posedge i_clk )
begin
        if ( i_commit && i_push )
        begin
                entries[ptr] <= i_push_addr;
        end
end

// The predictor never asks for both in one word.
a_push_pop_exclusive : assert property (
        @(posedge i_clk) disable iff (i_reset) !(i_push && i_pop)
);

endmodule : return_stack

//--- src/branch_classifier.sv
`timescale 1ns/1ps

`include "predecode_settings.svh"

module branch_classifier
(
        // Fetched word.
        input  logic [`PD_XLEN-1:0]          i_instr,
        input  logic                         i_valid,

        // Class and branch offset in bytes.
        output predecode_pkg::branch_class_e o_class,
        output logic [`PD_XLEN-1:0]          o_offset
);

logic is_branch;
logic is_return;
logic is_dp_to_pc;
logic is_load_to_pc;

// B and BL share bits 27:25.
assign is_branch = (i_instr[27:25] == 3'b101);

assign is_return = (i_instr ==? `PD_BX_LR_PATTERN) ||
                   (i_instr ==? `PD_MOV_PC_LR_PATTERN);

// ADD or MOV writing the PC.
// Multiplies and extra load/stores live in the same space, so skip them.
assign is_dp_to_pc = (i_instr[27:26] == 2'b00) &&
                     (i_instr[15:12] == `PD_REG_PC) &&
                     (i_instr[25] || !i_instr[4] || !i_instr[7]) &&
                     ((i_instr[24:21] == `PD_OP_ADD) ||
                      (i_instr[24:21] == `PD_OP_MOV));

// Single word or byte load with the PC as destination.
assign is_load_to_pc = (i_instr[27:26] == 2'b01) &&
                       !(i_instr[25] && i_instr[4]) &&
                       i_instr[20] &&
                       (i_instr[15:12] == `PD_REG_PC);

// Word offset, sign-extended and scaled to bytes.
assign o_offset = {{(`PD_XLEN-26){i_instr[23]}}, i_instr[23:0], 2'b00};

always_comb
begin
        o_class = predecode_pkg::class_none;

        if ( i_valid )
        begin
                if ( is_branch )
                begin
                        // Link bit marks a call.
                        o_class = i_instr[24] ? predecode_pkg::class_call :
                                                predecode_pkg::class_branch;
                end
                else if ( is_return )
                begin
                        o_class = predecode_pkg::class_return;
                end
                else if ( is_dp_to_pc || is_load_to_pc )
                begin
                        o_class = predecode_pkg::class_jump_table;
                end
                else
                begin
                        o_class = predecode_pkg::class_other;
                end
        end
end

endmodule : branch_classifier

//--- src/predecode_pkg.sv
`include "predecode_settings.svh"

package predecode_pkg;

        // Two-bit branch history state.
        typedef enum logic [1:0] {
                strongly_not_taken = 2'b00,
                weakly_not_taken   = 2'b01,
                weakly_taken       = 2'b10,
                strongly_taken     = 2'b11
        } taken_e;

        // Branch class of a fetched word.
        typedef enum logic [2:0] {
                class_none       = 3'd0,
                class_branch     = 3'd1,
                class_call       = 3'd2,
                class_return     = 3'd3,
                class_jump_table = 3'd4,
                class_other      = 3'd5
        } branch_class_e;

        // Word and branch guess from fetch.
        typedef struct packed {
                logic [`PD_XLEN-1:0] instr;
                logic                valid;
                logic [`PD_XLEN-1:0] pc;
                taken_e              taken;
                logic                btb_valid;
                logic [`PD_XLEN-1:0] btb_target;
        } fetch_bundle_t;

        // Registered word for the next stage.
        typedef struct packed {
                logic [`PD_XLEN-1:0] instr;
                logic                valid;
                logic [`PD_XLEN-1:0] pc;
                taken_e              taken;
                logic [`PD_XLEN-1:0] ppc;
        } decode_bundle_t;

        // Fetch redirect, with an optional BTB entry clear.
        typedef struct packed {
                logic                valid;
                logic [`PD_XLEN-1:0] target;
                logic                clear_btb;
        } redirect_t;

endpackage : predecode_pkg

//--- src/predecode_settings.svh
`ifndef PREDECODE_SETTINGS_SVH
`define PREDECODE_SETTINGS_SVH

// Width of a PC and of an instruction word.
`define PD_XLEN 32

// Default number of return stack entries.
`define PD_RAS_DEPTH 8

// PC advance for one instruction.
`define PD_INSTR_STEP 4

// --------------------------------------------------
// Instruction fields.
// --------------------------------------------------

// Condition code for always execute.
`define PD_COND_AL 4'b1110

// Data-processing opcodes in bits 24:21.
`define PD_OP_ADD 4'b0100
`define PD_OP_MOV 4'b1101

// Architectural register number of the PC.
`define PD_REG_PC 4'd15

// --------------------------------------------------
// Return forms, condition field is a wildcard.
// --------------------------------------------------
`define PD_BX_LR_PATTERN     32'b????_0001_0010_1111_1111_1111_0001_1110
`define PD_MOV_PC_LR_PATTERN 32'b????_0001_1010_0000_1111_0000_0000_1110

`endif
